/* hw/uart_frame_pkg.sv */
// shared constants for the UART string link
// framing, bit timing and FSM encodings; imported by the RTL and the testbench

package uart_frame_pkg;

	// sys_clk cycles per UART bit
	localparam logic [15:0] clks_per_bit = 16'd16;
	localparam int          data_bits    = 8;

	// frame delimiter '&', sent twice at each end
	localparam logic [7:0]  delim_char   = 8'h26;

	localparam int          max_payload  = 16;
	// holds 0 to max_payload
	localparam int          len_w        = 5;
	// byte k at bits 8k+7:8k
	localparam int          str_w        = max_payload * 8;

	// start, data and stop bits
	localparam int          char_clks    = clks_per_bit * 10;

	// deserializer states
	localparam logic [1:0]  rxs_idle     = 2'd0;
	localparam logic [1:0]  rxs_start    = 2'd1;
	localparam logic [1:0]  rxs_data     = 2'd2;
	localparam logic [1:0]  rxs_stop     = 2'd3;

	// transmit framer states
	localparam logic [2:0]  enc_idle     = 3'd0;
	localparam logic [2:0]  enc_open1    = 3'd1;
	localparam logic [2:0]  enc_open2    = 3'd2;
	localparam logic [2:0]  enc_payload  = 3'd3;
	localparam logic [2:0]  enc_close1   = 3'd4;
	localparam logic [2:0]  enc_close2   = 3'd5;

	// receive framer states
	localparam logic [1:0]  dec_hunt     = 2'd0;
	localparam logic [1:0]  dec_open2    = 2'd1;
	localparam logic [1:0]  dec_payload  = 2'd2;
	localparam logic [1:0]  dec_close2   = 2'd3;

endpackage

/* hw/uart_serial_tx.sv */
// UART serializer with one start bit, data_bits data bits LSB first and one stop bit
// pulse tx_start while tx_ready is high; tx_ready returns after the stop bit

`timescale 1ns/1ps

module uart_serial_tx
	import uart_frame_pkg::*;
(
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [7:0] tx_data,
	input  logic       tx_start,
	output logic       tx_ready,
	output logic       txd
);

	logic                 busy;
	logic [15:0]          baud_cnt;
	logic [3:0]           bit_cnt;
	logic [data_bits:0]   shift_q;
	logic                 bit_end;

	assign tx_ready = !busy;
	// last cycle of the current bit
	assign bit_end  = (baud_cnt == clks_per_bit - 16'd1);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy     <= 1'b0;
			baud_cnt <= '0;
			bit_cnt  <= '0;
			txd      <= 1'b1;
		end else if (!busy) begin
			baud_cnt <= '0;
			bit_cnt  <= '0;
			if (tx_start) begin
				busy <= 1'b1;
				// start bit goes out on the next cycle
				txd  <= 1'b0;
			end
		end else if (bit_end) begin
			baud_cnt <= '0;
			if (bit_cnt == 4'(data_bits + 1)) begin
				// stop bit done
				busy <= 1'b0;
				txd  <= 1'b1;
			end else begin
				bit_cnt <= bit_cnt + 4'd1;
				txd     <= shift_q[0];
			end
		end
		else begin
			baud_cnt <= baud_cnt + 16'd1;
		end
	end

	// data bits with the stop bit on top, moved down one place per bit
	always_ff @(posedge sys_clk) begin
		if (!busy && tx_start)
			shift_q <= {1'b1, tx_data};
		else if (busy && bit_end)
			shift_q <= {1'b1, shift_q[data_bits:1]};
	end

endmodule

/* hw/uart_serial_rx.sv */
// UART deserializer with a two-flop input synchronizer
// samples mid-bit and pulses rx_valid for one cycle per good character;
// a character with a low stop bit is dropped

`timescale 1ns/1ps

module uart_serial_rx
	import uart_frame_pkg::*;
(
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       rxd,
	output logic [7:0] rx_byte,
	output logic       rx_valid
);

	logic        rxd_meta;
	logic        rxd_sync;
	logic        rxd_prev;
	logic [1:0]  state;
	logic [15:0] baud_cnt;
	logic [3:0]  bit_cnt;
	logic        start_edge;
	logic        half_bit;
	logic        full_bit;

	// line idles high
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			rxd_prev <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_prev <= rxd_sync;
		end
	end

	assign start_edge = rxd_prev && !rxd_sync;
	assign half_bit   = (baud_cnt == (clks_per_bit >> 1) - 16'd1);
	assign full_bit   = (baud_cnt == clks_per_bit - 16'd1);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= rxs_idle;
			baud_cnt <= '0;
			bit_cnt  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			case (state)
				rxs_idle: begin
					baud_cnt <= '0;
					bit_cnt  <= '0;
					if (start_edge)
						state <= rxs_start;
				end
				rxs_start: begin
					if (half_bit) begin
						// glitch if the line is already back high
						baud_cnt <= '0;
						state    <= rxd_sync ? rxs_idle : rxs_data;
					end else begin
						baud_cnt <= baud_cnt + 16'd1;
					end
				end
				rxs_data: begin
					if (full_bit) begin
						baud_cnt <= '0;
						bit_cnt  <= bit_cnt + 4'd1;
						if (bit_cnt == 4'(data_bits - 1))
							state <= rxs_stop;
					end else begin
						baud_cnt <= baud_cnt + 16'd1;
					end
				end
				rxs_stop: begin
					if (full_bit) begin
						state    <= rxs_idle;
						rx_valid <= rxd_sync;
					end else begin
						baud_cnt <= baud_cnt + 16'd1;
					end
				end
				default: state <= rxs_idle;
			endcase
		end
	end

	// LSB arrives first, so shift in from the top
	always_ff @(posedge sys_clk) begin
		if (state == rxs_data && full_bit)
			rx_byte <= {rxd_sync, rx_byte[7:1]};
	end

endmodule

/* hw/frame_encoder.sv */
// transmit framer: sends "&&", tx_length payload bytes, then "&&"
// hands one byte to the serializer per tx_ready; tx_done marks the
// end of the last stop bit

`timescale 1ns/1ps

module frame_encoder
	import uart_frame_pkg::*;
(
	input  logic             sys_clk,
	input  logic             sys_rst_n,
	input  logic [str_w-1:0] tx_string,
	input  logic [len_w-1:0] tx_length,
	input  logic             tx_req,
	output logic             tx_busy,
	output logic             tx_done,
	output logic [7:0]       tx_data,
	output logic             tx_start,
	input  logic             tx_ready
);

	logic [2:0]       state;
	logic [str_w-1:0] str_q;
	logic [len_w-1:0] len_q;
	logic [len_w-1:0] idx;
	logic             last_sent;

	assign tx_busy = (state != enc_idle);

	// every busy state sends a byte when the serializer is free,
	// except close2 after its '&' has gone
	assign tx_start = tx_ready && tx_busy && !last_sent;
	assign tx_data  = (state == enc_payload) ? str_q[8*idx +: 8] : delim_char;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= enc_idle;
			idx       <= '0;
			last_sent <= 1'b0;
			tx_done   <= 1'b0;
		end else begin
			tx_done <= 1'b0;
			case (state)
				enc_idle: begin
					if (tx_req) begin
						state     <= enc_open1;
						idx       <= '0;
						last_sent <= 1'b0;
					end
				end
				enc_open1: begin
					if (tx_start)
						state <= enc_open2;
				end
				enc_open2: begin
					// empty string goes straight to the closing pair
					if (tx_start)
						state <= (len_q == '0) ? enc_close1 : enc_payload;
				end
				enc_payload: begin
					if (tx_start) begin
						if (idx == len_q - 1'b1)
							state <= enc_close1;
						else
							idx <= idx + 1'b1;
					end
				end
				enc_close1: begin
					if (tx_start)
						state <= enc_close2;
				end
				enc_close2: begin
					if (tx_start) begin
						last_sent <= 1'b1;
					end else if (last_sent && tx_ready) begin
						// serializer idle again, stop bit finished
						state     <= enc_idle;
						last_sent <= 1'b0;
						tx_done   <= 1'b1;
					end
				end
				default: state <= enc_idle;
			endcase
		end
	end

	// request capture, length clamped to the buffer size
	always_ff @(posedge sys_clk) begin
		if ((state == enc_idle) && tx_req) begin
			str_q <= tx_string;
			len_q <= (tx_length > len_w'(max_payload)) ? len_w'(max_payload) : tx_length;
		end
	end

endmodule

/* hw/frame_decoder.sv */
// receive framer: finds "&&" payload "&&" in the byte stream
// rx_done pulses with rx_string and rx_length; bad frames pulse rx_error
// and the decoder goes back to hunting for the opening delimiter

`timescale 1ns/1ps

module frame_decoder
	import uart_frame_pkg::*;
(
	input  logic             sys_clk,
	input  logic             sys_rst_n,
	input  logic [7:0]       rx_byte,
	input  logic             rx_valid,
	output logic [str_w-1:0] rx_string,
	output logic [len_w-1:0] rx_length,
	output logic             rx_busy,
	output logic             rx_done,
	output logic             rx_error
);

	logic [1:0]       state;
	logic [len_w-1:0] byte_cnt;
	logic [str_w-1:0] work_buf;
	logic             is_delim;
	logic             buf_full;
	logic             frame_end;
	logic             frame_bad;

	assign is_delim = (rx_byte == delim_char);
	assign buf_full = (byte_cnt == len_w'(max_payload));
	assign rx_busy  = (state != dec_hunt);

	// second closing '&'
	assign frame_end = rx_valid && (state == dec_close2) && is_delim;

	// lone '&' inside the payload, or one byte too many
	assign frame_bad = rx_valid &&
		(((state == dec_close2) && !is_delim) ||
		 ((state == dec_payload) && !is_delim && buf_full));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= dec_hunt;
			byte_cnt <= '0;
			rx_done  <= 1'b0;
			rx_error <= 1'b0;
		end else begin
			rx_done  <= frame_end;
			rx_error <= frame_bad;
			if (rx_valid) begin
				case (state)
					// anything but '&' is line noise here
					dec_hunt: begin
						if (is_delim)
							state <= dec_open2;
					end
					dec_open2: begin
						byte_cnt <= '0;
						state    <= is_delim ? dec_payload : dec_hunt;
					end
					dec_payload: begin
						if (is_delim)
							state <= dec_close2;
						else if (buf_full)
							state <= dec_hunt;
						else
							byte_cnt <= byte_cnt + 1'b1;
					end
					dec_close2: state <= dec_hunt;
					default:    state <= dec_hunt;
				endcase
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (rx_valid && (state == dec_payload) && !is_delim && !buf_full)
			work_buf[8*byte_cnt +: 8] <= rx_byte;
	end

	// publish the frame; stale bytes above the length read as zero
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_string <= '0;
			rx_length <= '0;
		end else if (frame_end) begin
			rx_length <= byte_cnt;
			for (int k = 0; k < max_payload; k++)
				rx_string[8*k +: 8] <= (k < byte_cnt) ? work_buf[8*k +: 8] : 8'h00;
		end
	end

endmodule

/* hw/uart_frame_top.sv */
// UART string link top level
// transmit path: frame_encoder into uart_serial_tx
// receive path: uart_serial_rx into frame_decoder

`timescale 1ns/1ps

module uart_frame_top
	import uart_frame_pkg::*;
(
	input  logic             sys_clk,
	input  logic             sys_rst_n,
	input  logic [str_w-1:0] tx_string,
	input  logic [len_w-1:0] tx_length,
	input  logic             tx_req,
	output logic             tx_busy,
	output logic             tx_done,
	output logic [str_w-1:0] rx_string,
	output logic [len_w-1:0] rx_length,
	output logic             rx_busy,
	output logic             rx_done,
	output logic             rx_error,
	input  logic             uart_rx_port,
	output logic             uart_tx_port
);

	logic [7:0] tx_data;
	logic       tx_start;
	logic       tx_ready;
	logic [7:0] rx_byte;
	logic       rx_valid;

	frame_encoder u_frame_encoder (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_string (tx_string),
		.tx_length (tx_length),
		.tx_req    (tx_req),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.tx_data   (tx_data),
		.tx_start  (tx_start),
		.tx_ready  (tx_ready)
	);

	uart_serial_tx u_uart_serial_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_data   (tx_data),
		.tx_start  (tx_start),
		.tx_ready  (tx_ready),
		.txd       (uart_tx_port)
	);

	uart_serial_rx u_uart_serial_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rxd       (uart_rx_port),
		.rx_byte   (rx_byte),
		.rx_valid  (rx_valid)
	);

	frame_decoder u_frame_decoder (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_byte   (rx_byte),
		.rx_valid  (rx_valid),
		.rx_string (rx_string),
		.rx_length (rx_length),
		.rx_busy   (rx_busy),
		.rx_done   (rx_done),
		.rx_error  (rx_error)
	);

endmodule

/* include/tb_lfsr.svh */
// Galois LFSR helpers for the testbench random stimulus
// the caller owns the 32-bit state; each bit taken steps it once

`ifndef TB_LFSR_SVH
`define TB_LFSR_SVH

// taps 32,22,2,1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
	return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

function automatic logic [7:0] lfsr_byte(ref logic [31:0] s);
	logic [7:0] b;
	for (int i = 0; i < 8; i++) begin
		s    = lfsr_step(s);
		b[i] = s[0];
	end
	return b;
endfunction

// payload may not hold the delimiter, so '&' becomes 'A'
function automatic logic [7:0] lfsr_payload_byte(ref logic [31:0] s);
	logic [7:0] b;
	b = lfsr_byte(s);
	return (b == 8'h26) ? 8'h41 : b;
endfunction

`endif

/* tests/tb_uart_frame.sv */
// testbench for the UART string link
// loopback round trips, line format monitor, request while busy and
// hand-built framing errors on the receive line

`timescale 1ns/1ps

module tb_uart_frame
	import uart_frame_pkg::*;
;

	`include "tb_lfsr.svh"

	logic             sys_clk;
	logic             sys_rst_n;
	logic [str_w-1:0] tx_string;
	logic [len_w-1:0] tx_length;
	logic             tx_req;
	logic             tx_busy;
	logic             tx_done;
	logic [str_w-1:0] rx_string;
	logic [len_w-1:0] rx_length;
	logic             rx_busy;
	logic             rx_done;
	logic             rx_error;
	logic             uart_tx_port;
	logic             rx_line;
	logic             line_sel;
	logic             direct_line;
	logic [31:0]      lfsr_state;
	logic [7:0]       line_q[$];
	int               lens[8];
	int               errors = 0;
	int               line_errors = 0;
	int               tests = 0;
	int               failed_tests = 0;
	int               tx_done_cnt = 0;
	int               rx_done_cnt = 0;
	int               rx_error_cnt = 0;

	// loopback unless a task drives the line by hand
	assign rx_line = line_sel ? direct_line : uart_tx_port;

	uart_frame_top u_uart_frame_top (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_string    (tx_string),
		.tx_length    (tx_length),
		.tx_req       (tx_req),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_string    (rx_string),
		.rx_length    (rx_length),
		.rx_busy      (rx_busy),
		.rx_done      (rx_done),
		.rx_error     (rx_error),
		.uart_rx_port (rx_line),
		.uart_tx_port (uart_tx_port)
	);

	always #4 sys_clk = ~sys_clk;

	always @(posedge sys_clk) begin
		if (tx_done)
			tx_done_cnt++;
		if (rx_done)
			rx_done_cnt++;
		if (rx_error)
			rx_error_cnt++;
	end

	a_done_drops_busy: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_done |-> !tx_busy)
		else begin
			$display("FAIL tx_busy expected 0 got 1 while tx_done is high");
			errors++;
		end

	a_busy_after_req: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(tx_req && !tx_busy) |=> tx_busy)
		else begin
			$display("FAIL tx_busy expected 1 got 0 after accepted tx_req");
			errors++;
		end

	// closing '&' arrives while the frame is still open
	a_busy_before_done: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_done |-> $past(rx_busy))
		else begin
			$display("FAIL rx_busy expected 1 got 0 in the cycle before rx_done");
			errors++;
		end

	a_done_or_error: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!(rx_done && rx_error))
		else begin
			$display("FAIL rx_error expected 0 got 1 together with rx_done");
			errors++;
		end

	// decodes the transmit line by bit timing with mid-bit samples
	always begin : line_monitor
		logic [7:0] b;
		logic [7:0] exp_b;
		@(negedge sys_clk);
		if (sys_rst_n && !uart_tx_port) begin
			repeat (clks_per_bit / 2) @(negedge sys_clk);
			assert (uart_tx_port == 1'b0) else begin
				$display("FAIL uart_tx_port start bit expected 0 got 1");
				errors++;
				line_errors++;
			end
			for (int i = 0; i < data_bits; i++) begin
				repeat (clks_per_bit) @(negedge sys_clk);
				b[i] = uart_tx_port;
			end
			repeat (clks_per_bit) @(negedge sys_clk);
			assert (uart_tx_port == 1'b1) else begin
				$display("FAIL uart_tx_port stop bit expected 1 got 0");
				errors++;
				line_errors++;
			end
			assert (line_q.size() != 0) else begin
				$display("character %h sent on uart_tx_port with no frame pending", b);
				errors++;
				line_errors++;
			end
			if (line_q.size() != 0) begin
				exp_b = line_q.pop_front();
				assert (b == exp_b) else begin
					$display("FAIL uart_tx_port char expected %h got %h", exp_b, b);
					errors++;
					line_errors++;
				end
			end
		end
	end

	task automatic expect_val(input string name, input logic [str_w-1:0] exp,
		input logic [str_w-1:0] got);
		assert (got === exp) else begin
			$display("FAIL %s expected %0h got %0h", name, exp, got);
			errors++;
		end
	endtask

	task automatic check_idle_outputs();
		expect_val("uart_tx_port", 1, uart_tx_port);
		expect_val("tx_busy", 0, tx_busy);
		expect_val("tx_done", 0, tx_done);
		expect_val("rx_busy", 0, rx_busy);
		expect_val("rx_done", 0, rx_done);
		expect_val("rx_error", 0, rx_error);
		expect_val("rx_length", 0, rx_length);
		expect_val("rx_string", 0, rx_string);
	endtask

	task automatic push_frame(input logic [str_w-1:0] s, input int len);
		line_q.push_back(delim_char);
		line_q.push_back(delim_char);
		for (int k = 0; k < len; k++)
			line_q.push_back(s[8*k +: 8]);
		line_q.push_back(delim_char);
		line_q.push_back(delim_char);
	endtask

	// sends one random frame in loopback; poke adds a request while busy
	task automatic round_trip(input int len, input bit poke);
		logic [str_w-1:0] s;
		logic [str_w-1:0] exp_s;
		int tx0;
		int rx0;
		int n;
		s = '0;
		exp_s = '0;
		for (int k = 0; k < max_payload; k++) begin
			s[8*k +: 8] = lfsr_payload_byte(lfsr_state);
			if (k < len)
				exp_s[8*k +: 8] = s[8*k +: 8];
		end
		tx0 = tx_done_cnt;
		rx0 = rx_done_cnt;
		@(negedge sys_clk);
		tx_string = s;
		tx_length = len_w'(len);
		tx_req = 1'b1;
		push_frame(s, len);
		@(negedge sys_clk);
		tx_req = 1'b0;
		if (poke) begin
			repeat (char_clks) @(negedge sys_clk);
			expect_val("tx_busy", 1, tx_busy);
			tx_string = ~s;
			tx_length = len_w'(3);
			tx_req = 1'b1;
			@(negedge sys_clk);
			tx_req = 1'b0;
		end
		n = 0;
		while ((tx_done_cnt < tx0 + 1 || rx_done_cnt < rx0 + 1) &&
			n < (len + 4) * char_clks * 2) begin
			@(negedge sys_clk);
			n++;
		end
		assert (n < (len + 4) * char_clks * 2) else begin
			$display("timeout waiting for tx_done and rx_done, length %0d", len);
			errors++;
		end
		expect_val("rx_length", len, rx_length);
		expect_val("rx_string", exp_s, rx_string);
		expect_val("tx_done count", tx0 + 1, tx_done_cnt);
		if (poke) begin
			repeat (2 * char_clks) @(negedge sys_clk);
			expect_val("tx_done count", tx0 + 1, tx_done_cnt);
			expect_val("tx_busy", 0, tx_busy);
			expect_val("pending line chars", 0, line_q.size());
		end
	endtask

	task automatic drive_char(input logic [7:0] b);
		logic [9:0] w;
		w = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			direct_line = w[i];
			repeat (clks_per_bit) @(negedge sys_clk);
		end
	endtask

	task automatic drive_text(input string t);
		for (int i = 0; i < t.len(); i++)
			drive_char(t[i]);
		// one idle character so the decoder settles
		direct_line = 1'b1;
		repeat (char_clks) @(negedge sys_clk);
	endtask

	task automatic report_test(input string name, input int err_before);
		tests++;
		if (errors != err_before)
			failed_tests++;
		$display("%-22s %s", name, (errors == err_before) ? "ok" : "errors");
	endtask

	initial begin
		int e0;
		int rx0;
		int er0;
		longint total_chars;
		longint limit_ns;
		sys_clk = 1'b0;
		sys_rst_n = 1'b0;
		tx_string = '0;
		tx_length = '0;
		tx_req = 1'b0;
		line_sel = 1'b0;
		direct_line = 1'b1;
		lfsr_state = 32'h0ac2_540d;
		lens[0] = 0;
		lens[1] = 1;
		lens[2] = max_payload;
		for (int i = 3; i < 8; i++)
			lens[i] = lfsr_byte(lfsr_state) % (max_payload + 1);

		// hand-built characters and idle gaps add 40 characters
		total_chars = 40;
		for (int i = 0; i < 8; i++)
			total_chars += lens[i] + 4;
		limit_ns = total_chars * char_clks * 8 * 2 + 40000;
		fork
			begin
				#(limit_ns);
				$display("watchdog expired after %0d ns, tests did not finish", limit_ns);
				$display("test failed");
				$finish;
			end
		join_none

		e0 = errors;
		repeat (5) @(negedge sys_clk);
		check_idle_outputs();
		repeat (5) @(negedge sys_clk);
		sys_rst_n = 1'b1;
		repeat (3) @(negedge sys_clk);
		check_idle_outputs();
		report_test("reset state", e0);

		e0 = errors;
		for (int i = 0; i < 6; i++)
			round_trip(lens[i], 1'b0);
		report_test("loopback round trip", e0);

		e0 = errors;
		round_trip(lens[6], 1'b1);
		report_test("request while busy", e0);

		e0 = errors;
		rx0 = rx_done_cnt;
		er0 = rx_error_cnt;
		line_sel = 1'b1;
		drive_text("Ux!0~q");
		drive_text("&x");
		expect_val("rx_done count", rx0, rx_done_cnt);
		expect_val("rx_error count", er0, rx_error_cnt);
		expect_val("rx_busy", 0, rx_busy);
		drive_text("&&ab&c");
		expect_val("rx_error count", er0 + 1, rx_error_cnt);
		// one payload byte past the limit and no closing pair
		drive_char(delim_char);
		drive_char(delim_char);
		for (int i = 0; i <= max_payload; i++)
			drive_char(8'h62);
		drive_text("");
		expect_val("rx_error count", er0 + 2, rx_error_cnt);
		expect_val("rx_done count", rx0, rx_done_cnt);
		line_sel = 1'b0;
		round_trip(lens[7], 1'b0);
		report_test("framing errors", e0);

		repeat (char_clks) @(negedge sys_clk);
		expect_val("pending line chars", 0, line_q.size());
		expect_val("tx_done count", 8, tx_done_cnt);
		tests++;
		if (line_errors != 0 || line_q.size() != 0)
			failed_tests++;
		$display("%-22s %s", "line format", (line_errors == 0) ? "ok" : "errors");

		$display("summary: %0d tests run, %0d with errors, %0d errors in all",
			tests, failed_tests, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

/* src.f */
+incdir+include
hw/uart_frame_pkg.sv
hw/uart_serial_tx.sv
hw/uart_serial_rx.sv
hw/frame_encoder.sv
hw/frame_decoder.sv
hw/uart_frame_top.sv
tests/tb_uart_frame.sv
